// File: source/lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [4:0]  reg_idx_t;

    // word-addressed on-chip data RAM, indexed by address bits 9:2
    localparam int RAM_ADDR_BITS = 8;
    localparam int RAM_WORDS     = 256;

    typedef enum logic [3:0] {
        LS_LB  = 4'd0,
        LS_LBU = 4'd1,
        LS_LH  = 4'd2,
        LS_LHU = 4'd3,
        LS_LW  = 4'd4,
        LS_LWL = 4'd5,
        LS_LWR = 4'd6,
        LS_SB  = 4'd8,
        LS_SH  = 4'd9,
        LS_SW  = 4'd10,
        LS_SWL = 4'd11,
        LS_SWR = 4'd12
    } ls_sel_t;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_ADEL     = 2'd1,
        EXC_ADES     = 2'd2,
        EXC_UPSTREAM = 2'd3
    } exc_code_t;

    // loads occupy the lower half of the selector space
    function automatic logic is_load(ls_sel_t sel);
        return (sel == LS_LB) || (sel == LS_LBU) || (sel == LS_LH) || (sel == LS_LHU) ||
               (sel == LS_LW) || (sel == LS_LWL) || (sel == LS_LWR);
    endfunction

endpackage

// File: source/ls_issue.sv
`timescale 1ns/1ps

module ls_issue import lsu_pkg::*; (
    input  logic      accept,
    input  word_t     addr,
    input  word_t     rt_data,
    input  ls_sel_t   sel,
    input  logic      has_exc,
    output exc_code_t exc_code,
    output logic      ram_en,
    output byte_en_t  ram_wen,
    output word_t     ram_wdata
);

    logic [1:0] off;
    byte_en_t   lanes;

    assign off = addr[1:0];

    // alignment faults, upstream fault wins
    always_comb begin
        exc_code = EXC_NONE;
        if (has_exc) begin
            exc_code = EXC_UPSTREAM;
        end else if ((sel == LS_LH || sel == LS_LHU) && off[0]) begin
            exc_code = EXC_ADEL;
        end else if (sel == LS_LW && off != 2'b00) begin
            exc_code = EXC_ADEL;
        end else if (sel == LS_SH && off[0]) begin
            exc_code = EXC_ADES;
        end else if (sel == LS_SW && off != 2'b00) begin
            exc_code = EXC_ADES;
        end
    end

    // lane selection and store data placement
    always_comb begin
        lanes     = '0;
        ram_wdata = '0;
        case (sel)
            LS_SB: begin
                lanes     = 4'b0001 << off;
                ram_wdata = {4{rt_data[7:0]}};
            end
            LS_SH: begin
                lanes     = off[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{rt_data[15:0]}};
            end
            LS_SW: begin
                lanes     = 4'b1111;
                ram_wdata = rt_data;
            end
            // SWL puts the top bytes of rt into lanes 0..k
            LS_SWL: begin
                lanes     = 4'b1111 >> ~off;
                ram_wdata = rt_data >> {~off, 3'b000};
            end
            // SWR puts the low bytes of rt into lanes k..3
            LS_SWR: begin
                lanes     = 4'b1111 << off;
                ram_wdata = rt_data << {off, 3'b000};
            end
            default: begin
                lanes     = '0;
                ram_wdata = '0;
            end
        endcase
    end

    // a faulting or idle cycle must never touch the array
    always_comb begin
        ram_en  = accept && (exc_code == EXC_NONE);
        ram_wen = lanes & {4{ram_en}};
    end

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ps

module data_ram import lsu_pkg::*; (
    input  logic     clk,
    input  logic     en,
    input  byte_en_t wen,
    input  word_t    addr,
    input  word_t    wdata,
    output word_t    rdata
);

    word_t                    mem [RAM_WORDS];
    logic [RAM_ADDR_BITS-1:0] idx;

    assign idx = addr[RAM_ADDR_BITS+1:2];

    // byte-lane writes
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (wen[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read register holds unless a read is issued
    always_ff @(posedge clk) begin
        if (en && wen == '0) begin
            rdata <= mem[idx];
        end
    end

    a_idx_known : assert property (@(posedge clk) en |-> !$isunknown(idx))
        else $error("data_ram: unknown word index on an enabled access");

endmodule

// File: source/load_merge.sv
`timescale 1ns/1ps

module load_merge import lsu_pkg::*; (
    input  word_t      rdata,
    input  logic [1:0] offset,
    input  ls_sel_t    sel,
    input  word_t      rt,
    output word_t      merged
);

    word_t       shifted;
    logic [15:0] half;
    word_t       lwl_mask;
    word_t       lwr_mask;

    assign shifted = rdata >> {offset, 3'b000};
    assign half    = offset[1] ? rdata[31:16] : rdata[15:0];

    // result bytes that come from memory
    assign lwl_mask = 32'hffff_ffff << {~offset, 3'b000};
    assign lwr_mask = 32'hffff_ffff >> {offset, 3'b000};

    always_comb begin
        merged = '0;
        case (sel)
            LS_LB: begin
                merged = {{24{shifted[7]}}, shifted[7:0]};
            end
            LS_LBU: begin
                merged = {24'h0, shifted[7:0]};
            end
            LS_LH: begin
                merged = {{16{half[15]}}, half};
            end
            LS_LHU: begin
                merged = {16'h0, half};
            end
            LS_LW: begin
                merged = rdata;
            end
            // low k+1 memory bytes land at the top, rt keeps the rest
            LS_LWL: begin
                merged = (rdata << {~offset, 3'b000}) | (rt & ~lwl_mask);
            end
            // memory bytes k..3 land at the bottom, rt keeps the top k
            LS_LWR: begin
                merged = (rdata >> {offset, 3'b000}) | (rt & ~lwr_mask);
            end
            default: begin
                merged = '0;
            end
        endcase
    end

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import lsu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    output logic       req_ready,
    output logic       accept,
    input  word_t      pc,
    input  word_t      addr,
    input  word_t      rt_data,
    input  ls_sel_t    sel,
    input  reg_idx_t   dst,
    input  exc_code_t  exc_code,
    input  word_t      merged,
    output logic [1:0] held_offset,
    output ls_sel_t    held_sel,
    output word_t      held_rt,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output word_t      rsp_pc,
    output word_t      rsp_data,
    output logic       rsp_w_reg_ena,
    output reg_idx_t   rsp_dst,
    output exc_code_t  rsp_exc
);

    logic      valid_q;
    word_t     pc_q;
    reg_idx_t  dst_q;
    exc_code_t exc_q;

    // stage frees up when empty or when the held item leaves this cycle
    assign req_ready = !valid_q || rsp_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (req_ready) begin
            valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q        <= pc;
            held_offset <= addr[1:0];
            held_sel    <= sel;
            held_rt     <= rt_data;
            dst_q       <= dst;
            exc_q       <= exc_code;
        end
    end

    assign rsp_valid     = valid_q;
    assign rsp_pc        = pc_q;
    assign rsp_dst       = dst_q;
    assign rsp_exc       = exc_q;
    assign rsp_w_reg_ena = is_load(held_sel) && (exc_q == EXC_NONE);
    assign rsp_data      = (exc_q == EXC_NONE) ? merged : '0;

    // rsp_data also depends on the RAM read register, so this covers the RAM hold too
    a_rsp_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=>
            rsp_valid && $stable(rsp_pc) && $stable(rsp_data) && $stable(rsp_w_reg_ena) &&
            $stable(rsp_dst) && $stable(rsp_exc)
    ) else $error("mem_stage: response changed under back-pressure");

endmodule

// File: source/lsu_badvaddr.sv
`timescale 1ns/1ps

module lsu_badvaddr import lsu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      accept,
    input  exc_code_t exc_code,
    input  word_t     addr,
    output word_t     badvaddr
);

    logic addr_fault;

    // only address errors raised here, not faults carried in from upstream
    assign addr_fault = (exc_code == EXC_ADEL) || (exc_code == EXC_ADES);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            badvaddr <= '0;
        end else if (accept && addr_fault) begin
            badvaddr <= addr;
        end
    end

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  word_t     req_pc,
    input  word_t     req_addr,
    input  word_t     req_rt_data,
    input  ls_sel_t   req_sel,
    input  reg_idx_t  req_dst,
    input  logic      req_has_exc,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output word_t     rsp_pc,
    output word_t     rsp_data,
    output logic      rsp_w_reg_ena,
    output reg_idx_t  rsp_dst,
    output exc_code_t rsp_exc,
    output word_t     badvaddr
);

    logic       accept;
    exc_code_t  exc_code;
    logic       ram_en;
    byte_en_t   ram_wen;
    word_t      ram_wdata;
    word_t      rdata;
    word_t      merged;
    logic [1:0] held_offset;
    ls_sel_t    held_sel;
    word_t      held_rt;

    ls_issue u_ls_issue (
        .accept    (accept),
        .addr      (req_addr),
        .rt_data   (req_rt_data),
        .sel       (req_sel),
        .has_exc   (req_has_exc),
        .exc_code  (exc_code),
        .ram_en    (ram_en),
        .ram_wen   (ram_wen),
        .ram_wdata (ram_wdata)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .wen   (ram_wen),
        .addr  (req_addr),
        .wdata (ram_wdata),
        .rdata (rdata)
    );

    mem_stage u_mem_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .accept        (accept),
        .pc            (req_pc),
        .addr          (req_addr),
        .rt_data       (req_rt_data),
        .sel           (req_sel),
        .dst           (req_dst),
        .exc_code      (exc_code),
        .merged        (merged),
        .held_offset   (held_offset),
        .held_sel      (held_sel),
        .held_rt       (held_rt),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_pc        (rsp_pc),
        .rsp_data      (rsp_data),
        .rsp_w_reg_ena (rsp_w_reg_ena),
        .rsp_dst       (rsp_dst),
        .rsp_exc       (rsp_exc)
    );

    load_merge u_load_merge (
        .rdata  (rdata),
        .offset (held_offset),
        .sel    (held_sel),
        .rt     (held_rt),
        .merged (merged)
    );

    lsu_badvaddr u_lsu_badvaddr (
        .clk      (clk),
        .arst_n   (arst_n),
        .accept   (accept),
        .exc_code (exc_code),
        .addr     (req_addr),
        .badvaddr (badvaddr)
    );

endmodule

// File: sim/lsu_ref.svh
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

typedef struct packed {
    word_t     pc;
    word_t     data;
    logic      wen;
    reg_idx_t  dst;
    exc_code_t exc;
    word_t     bva;
} exp_rsp_t;

word_t    shadow [RAM_WORDS];
exp_rsp_t exp_q [$];
word_t    exp_bva = '0;

function automatic exc_code_t expected_exc(ls_sel_t sel, word_t addr, logic has_exc);
    exc_code_t e = EXC_NONE;
    if (has_exc) begin
        e = EXC_UPSTREAM;
    end else if ((sel == LS_LH || sel == LS_LHU) && addr[0]) begin
        e = EXC_ADEL;
    end else if (sel == LS_LW && addr[1:0] != 2'b00) begin
        e = EXC_ADEL;
    end else if ((sel == LS_SH && addr[0]) || (sel == LS_SW && addr[1:0] != 2'b00)) begin
        e = EXC_ADES;
    end
    return e;
endfunction

// lane j of the addressed word, written lane by lane
function automatic void store_shadow(ls_sel_t sel, word_t addr, word_t rt);
    int    k;
    word_t w;
    k = int'(addr[1:0]);
    w = shadow[addr[9:2]];
    for (int j = 0; j < 4; j++) begin
        if ((sel == LS_SB && j == k) || (sel == LS_SH && (j == k || j == k + 1)) ||
            sel == LS_SW || (sel == LS_SWR && j >= k)) begin
            w[8*j +: 8] = rt[8*(j-k) +: 8];
        end else if (sel == LS_SWL && j <= k) begin
            // top bytes of rt go to the lanes at and below the offset
            w[8*j +: 8] = rt[8*(j+3-k) +: 8];
        end
    end
    shadow[addr[9:2]] = w;
endfunction

function automatic word_t load_value(ls_sel_t sel, word_t addr, word_t rt);
    int    k;
    word_t w;
    word_t r;
    k = int'(addr[1:0]);
    w = shadow[addr[9:2]];
    r = rt;
    case (sel)
        LS_LB:  r = {{24{w[8*k+7]}}, w[8*k +: 8]};
        LS_LBU: r = {24'h0, w[8*k +: 8]};
        LS_LH:  r = {{16{w[8*k+15]}}, w[8*k +: 16]};
        LS_LHU: r = {16'h0, w[8*k +: 16]};
        LS_LW:  r = w;
        LS_LWL: begin
            for (int j = 0; j <= k; j++) begin
                r[8*(j+3-k) +: 8] = w[8*j +: 8];
            end
        end
        LS_LWR: begin
            for (int j = k; j < 4; j++) begin
                r[8*(j-k) +: 8] = w[8*j +: 8];
            end
        end
        default: r = '0;
    endcase
    return r;
endfunction

function automatic void model_request(word_t pc, word_t addr, word_t rt, ls_sel_t sel,
                                      reg_idx_t dst, logic has_exc);
    exp_rsp_t e;
    logic     load;
    load   = sel inside {LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LW, LS_LWL, LS_LWR};
    e.pc   = pc;
    e.dst  = dst;
    e.exc  = expected_exc(sel, addr, has_exc);
    e.wen  = load && (e.exc == EXC_NONE);
    e.data = '0;
    if (e.exc == EXC_NONE && load) begin
        e.data = load_value(sel, addr, rt);
    end else if (e.exc == EXC_NONE) begin
        store_shadow(sel, addr, rt);
    end
    // upstream faults leave badvaddr alone
    if (e.exc == EXC_ADEL || e.exc == EXC_ADES) begin
        exp_bva = addr;
    end
    e.bva = exp_bva;
    exp_q.push_back(e);
endfunction

`endif

// File: sim/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    localparam int N_REQ      = 400;
    localparam int MAX_CYCLES = N_REQ * 4;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      req_valid;
    logic      req_ready;
    word_t     req_pc;
    word_t     req_addr;
    word_t     req_rt_data;
    ls_sel_t   req_sel;
    reg_idx_t  req_dst;
    logic      req_has_exc;
    logic      rsp_valid;
    logic      rsp_ready;
    word_t     rsp_pc;
    word_t     rsp_data;
    logic      rsp_w_reg_ena;
    reg_idx_t  rsp_dst;
    exc_code_t rsp_exc;
    word_t     badvaddr;

    `include "lsu_ref.svh"

    logic      acc_seen = 1'b0;
    int        pending = 0;
    int        cycles = 0;
    word_t     head_pc;
    word_t     head_data;
    logic      head_wen;
    reg_idx_t  head_dst;
    exc_code_t head_exc;
    word_t     head_bva;
    ls_sel_t   all_sels [12] = '{LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LW, LS_LWL, LS_LWR,
                                 LS_SB, LS_SH, LS_SW, LS_SWL, LS_SWR};

    lsu_top u_lsu_top (.*);

    always #10 clk = ~clk;

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic value_error(string field, word_t got, word_t want);
        $display("[FAIL] %0t: %s is %h, expected %h", $time, field, got, want);
        stop_failed();
    endtask

    // model runs on every transfer, head_* show the oldest outstanding response
    always @(posedge clk) begin
        if (rsp_valid && rsp_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        if (req_valid && req_ready) begin
            model_request(req_pc, req_addr, req_rt_data, req_sel, req_dst, req_has_exc);
        end
        acc_seen <= req_valid && req_ready;
        pending  <= exp_q.size();
        if (exp_q.size() > 0) begin
            head_pc   <= exp_q[0].pc;
            head_data <= exp_q[0].data;
            head_wen  <= exp_q[0].wen;
            head_dst  <= exp_q[0].dst;
            head_exc  <= exp_q[0].exc;
            head_bva  <= exp_q[0].bva;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: responses stalled, no end after %0d cycles", MAX_CYCLES);
            stop_failed();
        end
    end

    a_no_extra : assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> pending > 0)
        else begin
            $display("unexpected response at %0t with no request outstanding", $time);
            stop_failed();
        end
    a_latency : assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && req_ready |=> rsp_valid)
        else begin
            $display("response not valid one cycle after the request was accepted");
            stop_failed();
        end
    // the stage holds one item, so it is ready when nothing is outstanding or it drains
    a_ready : assert property (@(posedge clk) disable iff (!arst_n)
        req_ready == (pending == 0 || rsp_ready))
        else value_error("req_ready", 32'($sampled(req_ready)),
                         32'($sampled(pending) == 0 || $sampled(rsp_ready)));
    a_pc : assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> rsp_pc == head_pc)
        else value_error("rsp_pc", $sampled(rsp_pc), $sampled(head_pc));
    a_data : assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> rsp_data == head_data)
        else value_error("rsp_data", $sampled(rsp_data), $sampled(head_data));
    a_wen : assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> rsp_w_reg_ena == head_wen)
        else value_error("rsp_w_reg_ena", 32'($sampled(rsp_w_reg_ena)), 32'($sampled(head_wen)));
    a_dst : assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> rsp_dst == head_dst)
        else value_error("rsp_dst", 32'($sampled(rsp_dst)), 32'($sampled(head_dst)));
    a_exc : assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> rsp_exc == head_exc)
        else value_error("rsp_exc", 32'($sampled(rsp_exc)), 32'($sampled(head_exc)));
    a_bva : assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> badvaddr == head_bva)
        else value_error("badvaddr", $sampled(badvaddr), $sampled(head_bva));

    // falling edge, with a new random rsp_ready
    task automatic step();
        @(negedge clk);
        rsp_ready = ($urandom % 3) != 0;
    endtask

    // upper address bits are random, the RAM ignores them
    function automatic word_t byte_addr(int w, int off);
        word_t a;
        a       = $urandom;
        a[9:0]  = {w[7:0], off[1:0]};
        return a;
    endfunction

    task automatic send(ls_sel_t sel, word_t addr, word_t rt, logic has_exc);
        req_valid   = 1'b1;
        req_sel     = sel;
        req_addr    = addr;
        req_rt_data = rt;
        req_has_exc = has_exc;
        req_dst     = reg_idx_t'($urandom);
        req_pc      = req_pc + 32'd4;
        step();
        while (!acc_seen) begin
            step();
        end
    endtask

    initial begin
        int w;
        void'($urandom(32'h50cfa8fc));
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req_pc      = '0;
        req_addr    = '0;
        req_rt_data = '0;
        req_sel     = LS_LW;
        req_dst     = '0;
        req_has_exc = 1'b0;
        rsp_ready   = 1'b1;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        step();
        // fill the words under test, reading each one back
        for (int i = 0; i < 32; i++) begin
            send(LS_SW, byte_addr(i, 0), $urandom, 1'b0);
            send(LS_LW, byte_addr(i, 0), $urandom, 1'b0);
        end
        repeat (8) begin
            w = $urandom_range(0, 31);
            send(LS_SB, byte_addr(w, $urandom_range(0, 3)), $urandom, 1'b0);
            send(LS_SH, byte_addr(w, 2 * $urandom_range(0, 1)), $urandom, 1'b0);
            for (int k = 0; k < 4; k++) begin
                send(LS_LB, byte_addr(w, k), $urandom, 1'b0);
                send(LS_LBU, byte_addr(w, k), $urandom, 1'b0);
                if (k % 2 == 0) begin
                    send(LS_LH, byte_addr(w, k), $urandom, 1'b0);
                    send(LS_LHU, byte_addr(w, k), $urandom, 1'b0);
                end
            end
        end
        repeat (2) begin
            for (int k = 0; k < 4; k++) begin
                w = $urandom_range(0, 31);
                send(LS_SWL, byte_addr(w, k), $urandom, 1'b0);
                send(LS_LW, byte_addr(w, 0), $urandom, 1'b0);
                send(LS_SWR, byte_addr(w, k), $urandom, 1'b0);
                send(LS_LW, byte_addr(w, 0), $urandom, 1'b0);
                send(LS_LWL, byte_addr(w, k), $urandom, 1'b0);
                send(LS_LWR, byte_addr(w, k), $urandom, 1'b0);
            end
        end
        // misaligned accesses, each followed by a check of the word
        for (int k = 1; k < 4; k++) begin
            w = $urandom_range(0, 31);
            send(LS_LW, byte_addr(w, k), $urandom, 1'b0);
            send(LS_SW, byte_addr(w, k), $urandom, 1'b0);
            send(LS_LW, byte_addr(w, 0), $urandom, 1'b0);
            if (k != 2) begin
                send(LS_LH, byte_addr(w, k), $urandom, 1'b0);
                send(LS_LHU, byte_addr(w, k), $urandom, 1'b0);
                send(LS_SH, byte_addr(w, k), $urandom, 1'b0);
                send(LS_LW, byte_addr(w, 0), $urandom, 1'b0);
            end
        end
        repeat (8) begin
            w = $urandom_range(0, 31);
            send(all_sels[4'($urandom_range(0, 11))], byte_addr(w, $urandom_range(0, 3)),
                 $urandom, 1'b1);
            send(LS_LW, byte_addr(w, 0), $urandom, 1'b0);
        end
        repeat (120) begin
            send(all_sels[4'($urandom_range(0, 11))],
                 byte_addr($urandom_range(0, 31), $urandom_range(0, 3)), $urandom,
                 ($urandom % 8) == 0);
        end
        req_valid = 1'b0;
        // wait for the DUT to drain its last response
        while (rsp_valid) begin
            step();
        end
        if (exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("responses missing at the end, %0d still expected", exp_q.size());
            stop_failed();
        end
    end

endmodule

// File: sim.f
+incdir+sim
source/lsu_pkg.sv
source/ls_issue.sv
source/data_ram.sv
source/load_merge.sv
source/mem_stage.sv
source/lsu_badvaddr.sv
source/lsu_top.sv
sim/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
